/* src/isa_pkg.sv */
package isa_pkg;

    localparam int NUM_REGS = 16;
    localparam int IMM_WIDTH = 20;

    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_ADDI  = 4'h4,
        OP_TID   = 4'h5,
        OP_MASK  = 4'h6,
        OP_BNZ   = 4'h7,
        OP_STORE = 4'h8,
        OP_HALT  = 4'h9
    } opcode_t;

    // Register form, rs2 sits in the top bits of the immediate field
    typedef struct packed {
        opcode_t                                  opcode;
        reg_addr_t                                rd;
        reg_addr_t                                rs1;
        reg_addr_t                                rs2;
        logic [IMM_WIDTH-$bits(reg_addr_t)-1:0]   unused;
    } r_view_t;

    typedef struct packed {
        opcode_t                opcode;
        reg_addr_t              rd;
        reg_addr_t              rs1;
        logic [IMM_WIDTH-1:0]   imm;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } instr_t;

endpackage

/* src/core_pkg.sv */
package core_pkg;

    // Threads per warp
    localparam int NUM_LANES = 4;
    localparam int DATA_WIDTH = 32;
    // Word address of an instruction
    localparam int PC_WIDTH = 10;
    localparam int LANE_IDX_WIDTH = $clog2(NUM_LANES);

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [PC_WIDTH-1:0] pc_t;

    // One bit per lane
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [LANE_IDX_WIDTH-1:0] lane_idx_t;

    // One word per lane, lane 0 in the low word
    typedef data_t [NUM_LANES-1:0] lane_data_t;

endpackage

/* src/issue_if.sv */
`timescale 1ns/1ps

// Decoded instruction, one-cycle valid pulse
interface issue_if;
    import isa_pkg::*;
    import core_pkg::*;

    logic      valid;
    opcode_t   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     imm;
    data_t     offset;

    modport source (output valid, op, rd, rs1, rs2, imm, offset);
    modport sink (input valid, op, rd, rs1, rs2, imm, offset);
endinterface

// Per-lane store request toward the store unit
interface store_if;
    import core_pkg::*;

    logic       req;
    lane_mask_t mask;
    lane_data_t addr;
    lane_data_t data;
    logic       done;

    modport master (output req, mask, addr, data, input done);
    modport worker (input req, mask, addr, data, output done);
endinterface

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             retire,
    input  core_pkg::pc_t    next_pc,
    input  logic             halt,
    output logic             imem_cyc,
    output logic             imem_stb,
    output core_pkg::pc_t    imem_adr,
    input  isa_pkg::instr_t  imem_rdata,
    input  logic             imem_ack,
    output logic             fetched,
    output isa_pkg::instr_t  instr,
    output logic             halted
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_HALTED
    } fetch_state_t;

    fetch_state_t state;
    pc_t          pc;

    // Bus request is held for the whole request state
    assign imem_cyc = (state == ST_REQ);
    assign imem_stb = (state == ST_REQ);
    assign imem_adr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            pc      <= '0;
            fetched <= 1'b0;
            halted  <= 1'b0;
        end else begin
            fetched <= 1'b0;
            case (state)
                ST_IDLE, ST_HALTED: begin
                    if (start) begin
                        pc     <= '0;
                        halted <= 1'b0;
                        state  <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (imem_ack) begin
                        fetched <= 1'b1;
                        state   <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // Wait for execute to retire before the next fetch
                    if (retire) begin
                        if (halt) begin
                            halted <= 1'b1;
                            state  <= ST_HALTED;
                        end else begin
                            pc    <= next_pc;
                            state <= ST_REQ;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (imem_cyc && imem_ack) begin
            instr <= imem_rdata;
        end
    end

    a_stb_has_cyc: assert property (@(posedge clk) disable iff (reset)
        imem_stb |-> imem_cyc);

    // Address stays put while the slave inserts wait states
    a_req_held: assert property (@(posedge clk) disable iff (reset)
        (imem_stb && !imem_ack) |=> (imem_stb && $stable(imem_adr)));

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            fetched,
    input  isa_pkg::instr_t instr,
    issue_if.source         issue
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [IMM_WIDTH-1:0] raw_imm;
    data_t                imm_sext;
    data_t                imm_zext;

    // Immediate field seen through the i_view of the word
    assign raw_imm  = instr.i_view.imm;
    assign imm_sext = {{(DATA_WIDTH-IMM_WIDTH){raw_imm[IMM_WIDTH-1]}}, raw_imm};
    // Branch offsets are forward only
    assign imm_zext = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, raw_imm};

    always_ff @(posedge clk) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= fetched;
        end
    end

    // Fields hold until the next fetch so execute may read them late
    always_ff @(posedge clk) begin
        if (fetched) begin
            issue.op     <= instr.r_view.opcode;
            issue.rd     <= instr.r_view.rd;
            issue.rs1    <= instr.r_view.rs1;
            issue.rs2    <= instr.r_view.rs2;
            // ADDI and STORE use the signed form
            issue.imm    <= imm_sext;
            issue.offset <= imm_zext;
        end
    end

endmodule

/* src/lane_execute.sv */
`timescale 1ns/1ps

module lane_execute (
    input  logic          clk,
    input  logic          reset,
    input  logic          start,
    issue_if.sink         issue,
    store_if.master       store,
    output logic          retire,
    output core_pkg::pc_t next_pc,
    output logic          halt
);
    import isa_pkg::*;
    import core_pkg::*;

    data_t      regs [NUM_LANES][NUM_REGS];
    lane_mask_t mask;
    pc_t        pc;
    logic       store_busy;

    lane_data_t rs1_val;
    lane_data_t rs2_val;
    lane_data_t alu_res;
    lane_mask_t nonzero;
    logic       writes_rd;
    logic       branch_taken;

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            rs1_val[l] = regs[l][issue.rs1];
            rs2_val[l] = regs[l][issue.rs2];
            nonzero[l] = (rs1_val[l] != '0);
            case (issue.op)
                OP_ADD:  alu_res[l] = rs1_val[l] + rs2_val[l];
                OP_SUB:  alu_res[l] = rs1_val[l] - rs2_val[l];
                OP_AND:  alu_res[l] = rs1_val[l] & rs2_val[l];
                OP_OR:   alu_res[l] = rs1_val[l] | rs2_val[l];
                OP_ADDI: alu_res[l] = rs1_val[l] + issue.imm;
                OP_TID:  alu_res[l] = data_t'(l);
                default: alu_res[l] = '0;
            endcase
        end
    end

    assign writes_rd = issue.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_TID};

    // Uniform branch: every active lane must agree, empty mask never branches
    assign branch_taken = (mask != '0) && ((nonzero & mask) == mask);

    // Store vectors come straight from the held issue fields
    assign store.mask = mask;
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            store.addr[l] = rs1_val[l] + issue.imm;
            store.data[l] = rs2_val[l];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                for (int r = 0; r < NUM_REGS; r++) begin
                    regs[l][r] <= '0;
                end
            end
            mask       <= '1;
            pc         <= '0;
            next_pc    <= '0;
            retire     <= 1'b0;
            halt       <= 1'b0;
            store.req  <= 1'b0;
            store_busy <= 1'b0;
        end else begin
            retire    <= 1'b0;
            halt      <= 1'b0;
            store.req <= 1'b0;
            if (retire) begin
                pc <= next_pc;
            end
            if (issue.valid) begin
                if (issue.op == OP_BNZ && branch_taken) begin
                    next_pc <= pc + pc_t'(1) + issue.offset[PC_WIDTH-1:0];
                end else begin
                    next_pc <= pc + pc_t'(1);
                end
                if (writes_rd) begin
                    for (int l = 0; l < NUM_LANES; l++) begin
                        if (mask[l]) begin
                            regs[l][issue.rd] <= alu_res[l];
                        end
                    end
                end
                // MASK looks at all lanes, not only the active ones
                if (issue.op == OP_MASK) begin
                    mask <= nonzero;
                end
                if (issue.op == OP_STORE) begin
                    store.req  <= 1'b1;
                    store_busy <= 1'b1;
                end else begin
                    retire <= 1'b1;
                    halt   <= (issue.op == OP_HALT);
                end
            end else if (store_busy && store.done) begin
                store_busy <= 1'b0;
                retire     <= 1'b1;
            end
        end
    end

    // Fetch must not run ahead of an unfinished store
    a_no_issue_during_store: assert property (@(posedge clk) disable iff (reset)
        issue.valid |-> !store_busy);

endmodule

/* src/store_unit.sv */
`timescale 1ns/1ps

module store_unit (
    input  logic            clk,
    input  logic            reset,
    store_if.worker         store,
    output logic            dmem_cyc,
    output logic            dmem_stb,
    output logic            dmem_we,
    output core_pkg::data_t dmem_adr,
    output core_pkg::data_t dmem_wdata,
    input  logic            dmem_ack
);
    import core_pkg::*;

    lane_mask_t pending;
    lane_mask_t rest;
    lane_data_t addr_q;
    lane_data_t data_q;
    lane_idx_t  lane;
    lane_idx_t  first_lane;
    logic       active;

    // Lowest pending lane goes first
    always_comb begin
        first_lane = '0;
        for (int l = NUM_LANES - 1; l >= 0; l--) begin
            if (pending[l]) begin
                first_lane = lane_idx_t'(l);
            end
        end
    end

    assign rest = pending & ~(lane_mask_t'(1) << lane);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending    <= '0;
            lane       <= '0;
            active     <= 1'b0;
            store.done <= 1'b0;
        end else begin
            store.done <= 1'b0;
            if (store.req) begin
                pending    <= store.mask;
                store.done <= (store.mask == '0);
            end else if (active) begin
                // Drop the cycle on ack, next lane starts one cycle later
                if (dmem_ack) begin
                    active     <= 1'b0;
                    pending    <= rest;
                    store.done <= (rest == '0);
                end
            end else if (pending != '0) begin
                lane   <= first_lane;
                active <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store.req) begin
            addr_q <= store.addr;
            data_q <= store.data;
        end
    end

    assign dmem_cyc   = active;
    assign dmem_stb   = active;
    assign dmem_we    = active;
    assign dmem_adr   = addr_q[lane];
    assign dmem_wdata = data_q[lane];

    a_we_has_stb: assert property (@(posedge clk) disable iff (reset)
        dmem_we |-> dmem_stb);

    a_write_held: assert property (@(posedge clk) disable iff (reset)
        (dmem_stb && !dmem_ack) |=> (dmem_stb && $stable(dmem_adr) && $stable(dmem_wdata)));

endmodule

/* src/simt_core.sv */
`timescale 1ns/1ps

module simt_core (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    output logic            halted,
    output logic            imem_cyc,
    output logic            imem_stb,
    output core_pkg::pc_t   imem_adr,
    input  isa_pkg::instr_t imem_rdata,
    input  logic            imem_ack,
    output logic            dmem_cyc,
    output logic            dmem_stb,
    output logic            dmem_we,
    output core_pkg::data_t dmem_adr,
    output core_pkg::data_t dmem_wdata,
    input  logic            dmem_ack
);
    import isa_pkg::*;
    import core_pkg::*;

    logic   fetched;
    instr_t instr;
    logic   retire;
    pc_t    next_pc;
    logic   halt;

    issue_if issue_bus ();
    store_if store_bus ();

    fetch_stage fetch_inst (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .retire     (retire),
        .next_pc    (next_pc),
        .halt       (halt),
        .imem_cyc   (imem_cyc),
        .imem_stb   (imem_stb),
        .imem_adr   (imem_adr),
        .imem_rdata (imem_rdata),
        .imem_ack   (imem_ack),
        .fetched    (fetched),
        .instr      (instr),
        .halted     (halted)
    );

    decode_stage decode_inst (
        .clk     (clk),
        .reset   (reset),
        .fetched (fetched),
        .instr   (instr),
        .issue   (issue_bus.source)
    );

    lane_execute execute_inst (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .issue   (issue_bus.sink),
        .store   (store_bus.master),
        .retire  (retire),
        .next_pc (next_pc),
        .halt    (halt)
    );

    store_unit store_inst (
        .clk        (clk),
        .reset      (reset),
        .store      (store_bus.worker),
        .dmem_cyc   (dmem_cyc),
        .dmem_stb   (dmem_stb),
        .dmem_we    (dmem_we),
        .dmem_adr   (dmem_adr),
        .dmem_wdata (dmem_wdata),
        .dmem_ack   (dmem_ack)
    );

endmodule

/* tests/simt_model.svh */
`ifndef SIMT_MODEL_SVH
`define SIMT_MODEL_SVH

// ISA reference model running program_mem on four model lanes

data_t      model_regs [NUM_LANES][NUM_REGS];
lane_mask_t model_mask;
data_t      exp_addr [$];
data_t      exp_data [$];
pc_t        exp_pc [$];

task automatic run_model();
    pc_t        pc;
    instr_t     w;
    data_t      a;
    data_t      b;
    data_t      imm;
    lane_mask_t nz;
    bit         running;

    exp_addr.delete();
    exp_data.delete();
    exp_pc.delete();
    model_mask = '1;
    for (int l = 0; l < NUM_LANES; l++) begin
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[l][r] = '0;
        end
    end
    pc = '0;
    running = 1'b1;
    while (running) begin
        exp_pc.push_back(pc);
        w = fetch_word(pc);
        imm = data_t'($signed(w.i_view.imm));
        // rs1 test over every lane for MASK and BNZ
        for (int l = 0; l < NUM_LANES; l++) begin
            nz[l] = (model_regs[l][w.r_view.rs1] != 0);
        end
        case (w.r_view.opcode)
            OP_HALT: running = 1'b0;
            OP_MASK: model_mask = nz;
            OP_BNZ: begin
                if (model_mask != 0 && (nz & model_mask) == model_mask) begin
                    pc = pc + pc_t'(w.i_view.imm);
                end
            end
            OP_STORE: begin
                // Active lanes only, in ascending order
                for (int l = 0; l < NUM_LANES; l++) begin
                    if (model_mask[l]) begin
                        exp_addr.push_back(model_regs[l][w.r_view.rs1] + imm);
                        exp_data.push_back(model_regs[l][w.r_view.rs2]);
                    end
                end
            end
            default: begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    a = model_regs[l][w.r_view.rs1];
                    b = model_regs[l][w.r_view.rs2];
                    case (w.r_view.opcode)
                        OP_ADD:  a = a + b;
                        OP_SUB:  a = a - b;
                        OP_AND:  a = a & b;
                        OP_OR:   a = a | b;
                        OP_ADDI: a = a + imm;
                        default: a = data_t'(l);
                    endcase
                    if (model_mask[l]) begin
                        model_regs[l][w.r_view.rd] = a;
                    end
                end
            end
        endcase
        if (running) begin
            pc = pc + 1;
        end
    end
endtask

`endif

/* tests/simt_core_tb.sv */
`timescale 1ns/1ps

module simt_core_tb;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int PROGRAM_LEN = 40;
    localparam int NUM_PROGRAMS = 25;
    localparam int MAX_WAIT = 3;
    localparam int SEED = 42529;
    localparam int WATCHDOG_CYCLES = NUM_PROGRAMS * PROGRAM_LEN * 30;

    logic   clk = 1'b0;
    logic   reset;
    logic   start;
    logic   halted;
    logic   imem_cyc;
    logic   imem_stb;
    pc_t    imem_adr;
    instr_t imem_rdata = '0;
    logic   imem_ack = 1'b0;
    logic   dmem_cyc;
    logic   dmem_stb;
    logic   dmem_we;
    data_t  dmem_adr;
    data_t  dmem_wdata;
    logic   dmem_ack = 1'b0;

    instr_t      program_mem [0:PROGRAM_LEN];
    pc_t         fetch_q [$];
    data_t       wr_addr [$];
    data_t       wr_data [$];
    bit          imem_pending;
    int          imem_wait;
    pc_t         imem_req_adr;
    bit          dmem_pending;
    int          dmem_wait;
    data_t       dmem_req_adr;
    data_t       dmem_req_data;
    int unsigned seed_val;

    simt_core simt_core_inst (.*);

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Fail time %0t: %s is %h, expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    // Addresses past the program read as HALT
    function automatic instr_t fetch_word(input pc_t adr);
        instr_t halt_word;
        halt_word = '0;
        halt_word.r_view.opcode = OP_HALT;
        if (adr <= PROGRAM_LEN) begin
            return program_mem[adr];
        end
        return halt_word;
    endfunction

    `include "simt_model.svh"

    task automatic make_program();
        instr_t  w;
        opcode_t op;
        for (int i = 0; i < PROGRAM_LEN; i++) begin
            op = opcode_t'($urandom % 9);
            if ($urandom % 50 == 0) begin
                op = OP_HALT;
            end
            w = instr_t'($urandom);
            w.r_view.opcode = op;
            // Forward branch target stays on or before the final HALT
            if (op == OP_BNZ) begin
                w.i_view.imm = IMM_WIDTH'($urandom % (PROGRAM_LEN - i));
            end
            program_mem[i] = w;
        end
        w = '0;
        w.r_view.opcode = OP_HALT;
        program_mem[PROGRAM_LEN] = w;
    endtask

    task automatic check_quiet(input int cycles, input logic want_halted);
        repeat (cycles) begin
            @(negedge clk);
            check_value("halted", halted, want_halted);
            check_value("imem_cyc", imem_cyc, 1'b0);
            check_value("imem_stb", imem_stb, 1'b0);
            check_value("dmem_cyc", dmem_cyc, 1'b0);
            check_value("dmem_stb", dmem_stb, 1'b0);
            check_value("dmem_we", dmem_we, 1'b0);
        end
    endtask

    task automatic compare_run();
        for (int i = 0; i < exp_pc.size() && i < fetch_q.size(); i++) begin
            check_value("imem_adr", fetch_q[i], exp_pc[i]);
        end
        if (fetch_q.size() != exp_pc.size()) begin
            $display("Wrong number of fetches: %0d fetched, %0d expected",
                     fetch_q.size(), exp_pc.size());
            abort_run();
        end
        for (int i = 0; i < exp_addr.size() && i < wr_addr.size(); i++) begin
            check_value("dmem_adr", wr_addr[i], exp_addr[i]);
            check_value("dmem_wdata", wr_data[i], exp_data[i]);
        end
        if (wr_addr.size() != exp_addr.size()) begin
            $display("Missing or extra store: %0d written, %0d expected",
                     wr_addr.size(), exp_addr.size());
            abort_run();
        end
    endtask

    // Instruction slave with random wait states
    always @(posedge clk) begin
        if (reset) begin
            imem_ack <= 1'b0;
            imem_pending = 1'b0;
        end else if (imem_ack) begin
            imem_ack <= 1'b0;
            imem_pending = 1'b0;
        end else if (imem_cyc && imem_stb) begin
            if (!imem_pending) begin
                imem_pending = 1'b1;
                imem_req_adr = imem_adr;
                imem_wait = $urandom % (MAX_WAIT + 1);
            end
            check_value("imem_adr", imem_adr, imem_req_adr);
            if (imem_wait == 0) begin
                imem_ack <= 1'b1;
                imem_rdata <= fetch_word(imem_adr);
                fetch_q.push_back(imem_adr);
            end else begin
                imem_wait--;
            end
        end else if (imem_pending) begin
            $display("Instruction request dropped before ack at time %0t", $time);
            abort_run();
        end
    end

    // Data slave recording each completed write
    always @(posedge clk) begin
        if (reset) begin
            dmem_ack <= 1'b0;
            dmem_pending = 1'b0;
        end else if (dmem_ack) begin
            dmem_ack <= 1'b0;
            dmem_pending = 1'b0;
        end else if (dmem_cyc && dmem_stb) begin
            if (!dmem_pending) begin
                dmem_pending = 1'b1;
                dmem_req_adr = dmem_adr;
                dmem_req_data = dmem_wdata;
                dmem_wait = $urandom % (MAX_WAIT + 1);
            end
            check_value("dmem_we", dmem_we, 1'b1);
            check_value("dmem_adr", dmem_adr, dmem_req_adr);
            check_value("dmem_wdata", dmem_wdata, dmem_req_data);
            if (dmem_wait == 0) begin
                dmem_ack <= 1'b1;
                wr_addr.push_back(dmem_adr);
                wr_data.push_back(dmem_wdata);
            end else begin
                dmem_wait--;
            end
        end else if (dmem_pending) begin
            $display("Data write dropped before ack at time %0t", $time);
            abort_run();
        end
    end

    initial begin
        seed_val = $urandom(SEED);
        reset = 1'b1;
        start = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // Core stays idle while start is low
        check_quiet(8, 1'b0);
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            make_program();
            run_model();
            fetch_q.delete();
            wr_addr.delete();
            wr_data.delete();
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
            while (!halted) begin
                @(negedge clk);
            end
            check_quiet(6, 1'b1);
            compare_run();
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the programs did not all finish",
                 WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

/* simt_core.f */
+incdir+tests
src/isa_pkg.sv
src/core_pkg.sv
src/issue_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/lane_execute.sv
src/store_unit.sv
src/simt_core.sv
tests/simt_core_tb.sv
